// ==== design/arch_pkg.sv ====
package arch_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  localparam int ADDR_W    = 32;
  localparam int SEL_W     = 16;
  localparam int NUM_VEC   = 16;
  localparam int GATE_STEP = 4;

  ////////////////////////////////////////////////////////////
  // data words

  typedef logic [ADDR_W-1:0]          word_t;
  typedef logic [SEL_W-1:0]           sel_t;
  typedef logic [NUM_VEC-1:0]         vec_mask_t;
  typedef logic [$clog2(NUM_VEC)-1:0] vec_num_t;

  // gate word after byte swap
  typedef struct packed {
    sel_t                    selector;
    logic [ADDR_W-SEL_W-1:0] offset;
  } gate_word_t;

  typedef struct packed {
    logic [ADDR_W-SEL_W-1:0] unused;
    sel_t                    selector;
  } seg_frame_t;

  // popped stack word, full value or segment frame
  typedef union packed {
    word_t      value;
    seg_frame_t frame;
  } stack_word_u;

endpackage

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

  // one bit per pipeline stage
  typedef struct packed {
    logic fetch;
    logic decode_0;
    logic decode_1;
    logic register;
    logic address;
    logic execute;
    logic writeback;
  } flush_t;

  typedef struct packed {
    logic            fetch_load;
    arch_pkg::word_t fetch_address;
    logic            cs_load;
    arch_pkg::sel_t  cs;
    logic            eip_load;
    arch_pkg::word_t eip;
    logic            eflags_load;
    arch_pkg::word_t eflags;
    flush_t          flush;
  } redirect_t;

  typedef enum logic [2:0] {
    ret_idle,
    ret_pop_eflags,
    ret_pop_cs,
    ret_pop_eip
  } ret_state_t;

  localparam flush_t    flush_all     = '1;
  localparam flush_t    flush_none    = '0;
  localparam redirect_t redirect_none = '0;

endpackage

// ==== design/interrupt_entry.sv ====
`timescale 1ns/1ps

module interrupt_entry #(
  parameter arch_pkg::word_t idt_table [arch_pkg::NUM_VEC] = '{default: '0}
) (
  input  logic                or_int_vec,
  input  logic                reset,
  input  arch_pkg::vec_mask_t int_vec,
  input  logic                hold_int,
  output logic                pending_int,
  output logic                mem_valid,
  output arch_pkg::word_t     mem_address,
  input  logic                mem_dp_valid,
  input  arch_pkg::word_t     mem_dp_read_data,
  output ctrl_pkg::redirect_t int_redirect
);

  import arch_pkg::*;
  import ctrl_pkg::*;

  typedef enum logic [1:0] {
    ie_idle,
    ie_wait_lo,
    ie_wait_hi
  } ie_state_t;

  ie_state_t  state;
  vec_mask_t  pending;
  vec_mask_t  clear_mask;
  vec_num_t   pick;
  vec_num_t   cur_vec;
  logic       hi_req;
  logic       start;
  logic       done;
  gate_word_t lo_word;
  gate_word_t hi_word;

  // memory returns the gate little endian
  function automatic gate_word_t byte_swap(input word_t w);
    byte_swap = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  ////////////////////////////////////////////////////////////
  // pending vectors

  always_ff @(posedge or_int_vec) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending | int_vec) & ~clear_mask;
    end
  end

  assign pending_int = |pending;
  assign clear_mask  = done ? (vec_mask_t'(1) << cur_vec) : '0;

  // lowest pending line wins
  always_comb begin
    pick = '0;
    for (int i = NUM_VEC - 1; i >= 0; i--) begin
      if (pending[i]) begin
        pick = vec_num_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // gate reads

  assign start = (state == ie_idle) && pending_int && !hold_int;
  assign done  = (state == ie_wait_hi) && mem_dp_valid;

  assign mem_valid   = start | hi_req;
  assign mem_address = (state == ie_idle) ? idt_table[pick]
                                          : idt_table[cur_vec] + word_t'(GATE_STEP);

  always_ff @(posedge or_int_vec) begin
    if (reset) begin
      state  <= ie_idle;
      hi_req <= 1'b0;
    end else begin
      hi_req <= 1'b0;
      case (state)
        ie_idle: begin
          if (start) begin
            state <= ie_wait_lo;
          end
        end
        ie_wait_lo: begin
          if (mem_dp_valid) begin
            state  <= ie_wait_hi;
            hi_req <= 1'b1;
          end
        end
        ie_wait_hi: begin
          if (mem_dp_valid) begin
            state <= ie_idle;
          end
        end
        default: state <= ie_idle;
      endcase
    end
  end

  // vector is fixed for the whole service
  always_ff @(posedge or_int_vec) begin
    if (start) begin
      cur_vec <= pick;
    end
    if ((state == ie_wait_lo) && mem_dp_valid) begin
      lo_word <= byte_swap(mem_dp_read_data);
    end
  end

  assign hi_word = byte_swap(mem_dp_read_data);

  ////////////////////////////////////////////////////////////
  // redirect

  always_comb begin
    int_redirect               = redirect_none;
    int_redirect.fetch_load    = done;
    int_redirect.fetch_address = {hi_word.selector, lo_word.offset};
    int_redirect.cs_load       = done;
    int_redirect.cs            = hi_word.selector;
    int_redirect.flush         = done ? flush_all : flush_none;
  end

endmodule

// ==== design/redirect_merge.sv ====
`timescale 1ns/1ps

module redirect_merge (
  input  logic                or_int_vec,
  input  logic                reset,
  input  logic                jump_load,
  input  arch_pkg::word_t     jump_address,
  input  logic                jump_load_cs,
  input  arch_pkg::sel_t      jump_cs,
  input  ctrl_pkg::redirect_t int_redirect,
  input  ctrl_pkg::redirect_t ret_redirect,
  output ctrl_pkg::redirect_t redirect
);

  import arch_pkg::*;
  import ctrl_pkg::*;

  logic      jump_q;
  logic      jump_cs_load_q;
  word_t     jump_address_q;
  sel_t      jump_cs_q;
  redirect_t jump_redirect;
  redirect_t src [3];

  ////////////////////////////////////////////////////////////
  // jump register

  always_ff @(posedge or_int_vec) begin
    if (reset) begin
      jump_q         <= 1'b0;
      jump_cs_load_q <= 1'b0;
    end else begin
      jump_q         <= jump_load;
      jump_cs_load_q <= jump_load && jump_load_cs;
    end
  end

  always_ff @(posedge or_int_vec) begin
    if (jump_load) begin
      jump_address_q <= jump_address;
      jump_cs_q      <= jump_cs;
    end
  end

  always_comb begin
    jump_redirect                 = redirect_none;
    jump_redirect.fetch_load      = jump_q;
    jump_redirect.fetch_address   = jump_address_q;
    jump_redirect.cs_load         = jump_cs_load_q;
    jump_redirect.cs              = jump_cs_q;
    jump_redirect.flush           = jump_q ? flush_all : flush_none;
    jump_redirect.flush.writeback = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // merge, index 0 has highest priority

  assign src[0] = int_redirect;
  assign src[1] = ret_redirect;
  assign src[2] = jump_redirect;

  always_comb begin
    redirect = redirect_none;
    for (int s = 2; s >= 0; s--) begin
      redirect.flush = redirect.flush | src[s].flush;
      if (src[s].fetch_load) begin
        redirect.fetch_load    = 1'b1;
        redirect.fetch_address = src[s].fetch_address;
      end
      if (src[s].cs_load) begin
        redirect.cs_load = 1'b1;
        redirect.cs      = src[s].cs;
      end
      if (src[s].eip_load) begin
        redirect.eip_load = 1'b1;
        redirect.eip      = src[s].eip;
      end
      if (src[s].eflags_load) begin
        redirect.eflags_load = 1'b1;
        redirect.eflags      = src[s].eflags;
      end
    end
  end

endmodule

// ==== design/return_sequencer.sv ====
`timescale 1ns/1ps

module return_sequencer (
  input  logic                  or_int_vec,
  input  logic                  reset,
  input  logic                  iretd,
  input  logic                  ret_far,
  input  logic                  ret_near,
  input  logic                  iretd_pop_valid,
  input  arch_pkg::stack_word_u iretd_pop_data,
  output logic                  iretd_halt,
  output ctrl_pkg::redirect_t   ret_redirect
);

  import ctrl_pkg::*;

  ret_state_t state;
  logic       pop_eflags;
  logic       pop_cs;
  logic       pop_eip;

  assign pop_eflags = iretd_pop_valid && (state == ret_pop_eflags);
  assign pop_cs     = iretd_pop_valid && (state == ret_pop_cs);
  assign pop_eip    = iretd_pop_valid && (state == ret_pop_eip);
  assign iretd_halt = (state != ret_idle);

  // iretd pops eflags, cs, eip; far ret skips eflags
  always_ff @(posedge or_int_vec) begin
    if (reset) begin
      state <= ret_idle;
    end else begin
      case (state)
        ret_idle: begin
          if (iretd) begin
            state <= ret_pop_eflags;
          end else if (ret_far) begin
            state <= ret_pop_cs;
          end else if (ret_near) begin
            state <= ret_pop_eip;
          end
        end
        ret_pop_eflags: if (iretd_pop_valid) state <= ret_pop_cs;
        ret_pop_cs:     if (iretd_pop_valid) state <= ret_pop_eip;
        ret_pop_eip:    if (iretd_pop_valid) state <= ret_idle;
        default:        state <= ret_idle;
      endcase
    end
  end

  always_comb begin
    ret_redirect               = redirect_none;
    ret_redirect.eflags_load   = pop_eflags;
    ret_redirect.eflags        = iretd_pop_data.value;
    ret_redirect.cs_load       = pop_cs;
    ret_redirect.cs            = iretd_pop_data.frame.selector;
    ret_redirect.eip_load      = pop_eip;
    ret_redirect.eip           = iretd_pop_data.value;
    ret_redirect.fetch_load    = pop_eip;
    ret_redirect.fetch_address = iretd_pop_data.value;
    // fetch stays flushed while popping
    ret_redirect.flush.fetch    = iretd_halt;
    ret_redirect.flush.decode_0 = pop_eip;
    ret_redirect.flush.decode_1 = pop_eip;
    ret_redirect.flush.register = pop_eip;
    ret_redirect.flush.address  = pop_eip;
  end

endmodule

// ==== design/sys_control.sv ====
`timescale 1ns/1ps

module sys_control #(
  parameter arch_pkg::word_t idt_table [arch_pkg::NUM_VEC] = '{
    32'h4000, 32'h8000, 32'hc000, 32'hf000,
    32'hf000, 32'hf000, 32'hf000, 32'hf000,
    32'h4000, 32'h8000, 32'hc000, 32'hf000,
    32'h0100, 32'h2068, 32'h2070, 32'hf000
  }
) (
  input  logic                  or_int_vec,
  input  logic                  reset,
  input  arch_pkg::vec_mask_t   int_vec,
  input  logic                  hold_int,
  output logic                  pending_int,
  output logic                  mem_valid,
  output arch_pkg::word_t       mem_address,
  input  logic                  mem_dp_valid,
  input  arch_pkg::word_t       mem_dp_read_data,
  input  logic                  iretd,
  input  logic                  ret_far,
  input  logic                  ret_near,
  input  logic                  iretd_pop_valid,
  input  arch_pkg::stack_word_u iretd_pop_data,
  output logic                  iretd_halt,
  input  logic                  jump_load,
  input  arch_pkg::word_t       jump_address,
  input  logic                  jump_load_cs,
  input  arch_pkg::sel_t        jump_cs,
  output ctrl_pkg::redirect_t   redirect
);

  import ctrl_pkg::*;

  redirect_t int_redirect;
  redirect_t ret_redirect;

  interrupt_entry #(
    .idt_table (idt_table)
  ) i_interrupt_entry (
    .or_int_vec       (or_int_vec),
    .reset            (reset),
    .int_vec          (int_vec),
    .hold_int         (hold_int),
    .pending_int      (pending_int),
    .mem_valid        (mem_valid),
    .mem_address      (mem_address),
    .mem_dp_valid     (mem_dp_valid),
    .mem_dp_read_data (mem_dp_read_data),
    .int_redirect     (int_redirect)
  );

  return_sequencer i_return_sequencer (
    .or_int_vec      (or_int_vec),
    .reset           (reset),
    .iretd           (iretd),
    .ret_far         (ret_far),
    .ret_near        (ret_near),
    .iretd_pop_valid (iretd_pop_valid),
    .iretd_pop_data  (iretd_pop_data),
    .iretd_halt      (iretd_halt),
    .ret_redirect    (ret_redirect)
  );

  redirect_merge i_redirect_merge (
    .or_int_vec   (or_int_vec),
    .reset        (reset),
    .jump_load    (jump_load),
    .jump_address (jump_address),
    .jump_load_cs (jump_load_cs),
    .jump_cs      (jump_cs),
    .int_redirect (int_redirect),
    .ret_redirect (ret_redirect),
    .redirect     (redirect)
  );

endmodule

// ==== files.f ====
+incdir+tests
design/arch_pkg.sv
design/ctrl_pkg.sv
design/interrupt_entry.sv
design/return_sequencer.sv
design/redirect_merge.sv
design/sys_control.sv
tests/clock_gen.sv
tests/sys_control_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module sys_control_tb -f files.f -o sim \
  && ./obj_dir/sim > sim.log \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic or_int_vec,
  output logic reset
);

  // 4 ns period
  initial begin
    or_int_vec = 1'b0;
    forever #2 or_int_vec = ~or_int_vec;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge or_int_vec);
    reset <= 1'b0;
  end

endmodule

// ==== tests/tb_cases.svh ====
// jump: w0 address, w1 cs, opt sets jump_load_cs
// iretd: w0 eflags, w1 cs frame, w2 eip; ret_far: w0 cs, w1 eip; ret_near: w0 eip
// interrupt: vec lines, opt holds hold_int, exp_a and exp_b gate addresses lowest first

typedef enum logic [2:0] {k_jump, k_iretd, k_ret_far, k_ret_near, k_int} kind_t;

typedef struct packed {
  kind_t       kind;
  logic [31:0] w0;
  logic [31:0] w1;
  logic [31:0] w2;
  logic [15:0] vec;
  logic        opt;
  logic [31:0] exp_a;
  logic [31:0] exp_b;
} case_t;

localparam int num_cases = 7;

localparam case_t cases [num_cases] = '{
  '{k_jump,     32'h0010_2000, 32'h0000_0008, 32'h0, 16'h0000, 1'b0, 32'h0, 32'h0},
  '{k_jump,     32'h0000_7ff0, 32'h0000_0023, 32'h0, 16'h0000, 1'b1, 32'h0, 32'h0},
  '{k_iretd,    32'h0000_0246, 32'hdead_001b, 32'h0040_1000, 16'h0000, 1'b0, 32'h0, 32'h0},
  '{k_ret_far,  32'h5555_0010, 32'h0000_8abc, 32'h0, 16'h0000, 1'b0, 32'h0, 32'h0},
  '{k_ret_near, 32'h0000_3344, 32'h0, 32'h0, 16'h0000, 1'b0, 32'h0, 32'h0},
  '{k_int,      32'h0, 32'h0, 32'h0, 16'h1008, 1'b0, 32'h0000_f000, 32'h0000_0100},
  '{k_int,      32'h0, 32'h0, 32'h0, 16'h2000, 1'b1, 32'h0000_2068, 32'h0}
};

// ==== tests/sys_control_tb.sv ====
`timescale 1ns/1ps

module sys_control_tb;

  import arch_pkg::*;
  import ctrl_pkg::*;

  `include "tb_cases.svh"

  logic        or_int_vec;
  logic        reset;
  vec_mask_t   int_vec;
  logic        hold_int;
  logic        pending_int;
  logic        mem_valid;
  word_t       mem_address;
  logic        mem_dp_valid = 1'b0;
  word_t       mem_dp_read_data = '0;
  logic        iretd;
  logic        ret_far;
  logic        ret_near;
  logic        iretd_pop_valid;
  stack_word_u iretd_pop_data;
  logic        iretd_halt;
  logic        jump_load;
  word_t       jump_address;
  logic        jump_load_cs;
  sel_t        jump_cs;
  redirect_t   redirect;

  int          errors;
  int          case_errors;
  int          failed_cases;
  logic [31:0] rnd_state = 32'h4cd3_b382;
  logic        mem_req_seen = 1'b0;
  logic        mem_stage = 1'b0;
  word_t       mem_stage_data = '0;
  word_t       mem_log [$];
  word_t       addr_log [$];

  clock_gen i_clock_gen (.or_int_vec(or_int_vec), .reset(reset));

  sys_control i_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [3:0] loads(input redirect_t r);
    return {r.fetch_load, r.cs_load, r.eip_load, r.eflags_load};
  endfunction

  task automatic value_error(input string name, input word_t got, input word_t want);
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    case_errors++;
  endtask

  // data fields only matter where the load bit is set
  task automatic compare_redirect(input redirect_t want);
    if (loads(redirect) !== loads(want))
      value_error("load bits", 32'(loads(redirect)), 32'(loads(want)));
    if (redirect.flush !== want.flush)
      value_error("flush", 32'(redirect.flush), 32'(want.flush));
    if (want.fetch_load && redirect.fetch_address !== want.fetch_address)
      value_error("fetch_address", redirect.fetch_address, want.fetch_address);
    if (want.cs_load && redirect.cs !== want.cs)
      value_error("cs", 32'(redirect.cs), 32'(want.cs));
    if (want.eip_load && redirect.eip !== want.eip)
      value_error("eip", redirect.eip, want.eip);
    if (want.eflags_load && redirect.eflags !== want.eflags)
      value_error("eflags", redirect.eflags, want.eflags);
  endtask

  ////////////////////////////////////////////////////////////
  // memory model answering two cycles after each request

  always @(negedge or_int_vec) begin
    mem_req_seen = mem_valid;
    if (mem_valid)
      addr_log.push_back(mem_address);
  end

  always @(posedge or_int_vec) begin
    mem_stage        <= mem_req_seen;
    mem_dp_valid     <= mem_stage;
    mem_dp_read_data <= mem_stage_data;
    if (mem_req_seen) begin
      rnd_state = xorshift(rnd_state);
      mem_stage_data <= rnd_state;
      mem_log.push_back(rnd_state);
    end
  end

  ////////////////////////////////////////////////////////////
  // case runners

  task automatic jump_and_check(input case_t c);
    redirect_t want;
    @(posedge or_int_vec);
    jump_load    <= 1'b1;
    jump_address <= c.w0;
    jump_load_cs <= c.opt;
    jump_cs      <= c.w1[15:0];
    @(negedge or_int_vec);
    compare_redirect(redirect_none);
    @(posedge or_int_vec);
    jump_load    <= 1'b0;
    jump_load_cs <= 1'b0;
    @(negedge or_int_vec);
    want               = redirect_none;
    want.fetch_load    = 1'b1;
    want.fetch_address = c.w0;
    want.cs_load       = c.opt;
    want.cs            = c.w1[15:0];
    want.flush         = 7'b1111110;
    compare_redirect(want);
  endtask

  task automatic pop_return_words(input case_t c);
    redirect_t want;
    word_t     words [3];
    word_t     w;
    int        first;
    words = '{c.w0, c.w1, c.w2};
    first = (c.kind == k_iretd) ? 0 : ((c.kind == k_ret_far) ? 1 : 2);
    @(posedge or_int_vec);
    iretd    <= (c.kind == k_iretd);
    ret_far  <= (c.kind == k_ret_far);
    ret_near <= (c.kind == k_ret_near);
    @(negedge or_int_vec);
    if (iretd_halt)
      value_error("iretd_halt", 32'(iretd_halt), 32'h0);
    @(posedge or_int_vec);
    iretd    <= 1'b0;
    ret_far  <= 1'b0;
    ret_near <= 1'b0;
    // steps 0 to 2 pop eflags, cs and eip
    for (int s = first; s < 3; s++) begin
      w = words[s - first];
      @(negedge or_int_vec);
      if (!iretd_halt)
        value_error("iretd_halt", 32'(iretd_halt), 32'h1);
      @(posedge or_int_vec);
      iretd_pop_valid <= 1'b1;
      iretd_pop_data  <= w;
      @(negedge or_int_vec);
      want               = redirect_none;
      want.flush         = (s == 2) ? 7'b1111100 : 7'b1000000;
      want.eflags_load   = (s == 0);
      want.eflags        = w;
      want.cs_load       = (s == 1);
      want.cs            = w[15:0];
      want.eip_load      = (s == 2);
      want.eip           = w;
      want.fetch_load    = (s == 2);
      want.fetch_address = w;
      compare_redirect(want);
      @(posedge or_int_vec);
      iretd_pop_valid <= 1'b0;
    end
    @(negedge or_int_vec);
    if (iretd_halt)
      value_error("iretd_halt", 32'(iretd_halt), 32'h0);
  endtask

  task automatic service_interrupts(input case_t c);
    redirect_t want;
    word_t     lo;
    word_t     hi;
    word_t     gate;
    int        n;
    n = $countones(c.vec);
    mem_log.delete();
    addr_log.delete();
    @(posedge or_int_vec);
    int_vec  <= c.vec;
    hold_int <= c.opt;
    @(posedge or_int_vec);
    int_vec <= '0;
    if (c.opt) begin
      repeat (6) begin
        @(negedge or_int_vec);
        if (mem_valid)
          value_error("mem_valid", 32'(mem_valid), 32'h0);
      end
      @(posedge or_int_vec);
      hold_int <= 1'b0;
    end
    for (int k = 0; k < n; k++) begin
      @(negedge or_int_vec);
      if (k > 0 && !pending_int)
        value_error("pending_int", 32'(pending_int), 32'h1);
      while (!redirect.fetch_load)
        @(negedge or_int_vec);
      gate = (k == 0) ? c.exp_a : c.exp_b;
      lo   = {<<8{mem_log[2*k]}};
      hi   = {<<8{mem_log[2*k+1]}};
      want               = redirect_none;
      want.fetch_load    = 1'b1;
      want.fetch_address = {hi[31:16], lo[15:0]};
      want.cs_load       = 1'b1;
      want.cs            = hi[31:16];
      want.flush         = '1;
      compare_redirect(want);
      if (addr_log[2*k] !== gate)
        value_error("first gate address", addr_log[2*k], gate);
      if (addr_log[2*k+1] !== gate + 32'd4)
        value_error("second gate address", addr_log[2*k+1], gate + 32'd4);
    end
    @(negedge or_int_vec);
    if (pending_int)
      value_error("pending_int", 32'(pending_int), 32'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int_vec         = '0;
    hold_int        = 1'b0;
    iretd           = 1'b0;
    ret_far         = 1'b0;
    ret_near        = 1'b0;
    iretd_pop_valid = 1'b0;
    iretd_pop_data  = '0;
    jump_load       = 1'b0;
    jump_address    = '0;
    jump_load_cs    = 1'b0;
    jump_cs         = '0;
    errors          = 0;
    failed_cases    = 0;
    case_errors     = 0;
    @(negedge reset);
    @(negedge or_int_vec);
    compare_redirect(redirect_none);
    if (mem_valid)
      value_error("mem_valid", 32'(mem_valid), 32'h0);
    if (iretd_halt)
      value_error("iretd_halt", 32'(iretd_halt), 32'h0);
    if (pending_int)
      value_error("pending_int", 32'(pending_int), 32'h0);
    errors = case_errors;
    for (int i = 0; i < num_cases; i++) begin
      case_errors = 0;
      case (cases[i].kind)
        k_jump:  jump_and_check(cases[i]);
        k_int:   service_interrupts(cases[i]);
        default: pop_return_words(cases[i]);
      endcase
      errors += case_errors;
      if (case_errors != 0) begin
        failed_cases++;
        $display("case %0d %s failed", i, cases[i].kind.name());
      end else begin
        $display("case %0d %s ok", i, cases[i].kind.name());
      end
      repeat (2) @(posedge or_int_vec);
    end
    $display("%0d cases, %0d failed, %0d errors", num_cases, failed_cases, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // 40 cycles per case plus reset
  initial begin
    #((num_cases * 40 + 8) * 4);
    $display("timeout, the cases did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
